// File: cam_stream_pkg.sv
package cam_stream_pkg;

    //////////////////////////////////////////////////////////////////////
    // pixel stream types

    // row or column index inside a frame
    typedef logic [15:0] pos_t;

    // one camera beat, both channels side by side
    typedef struct packed {
        logic       valid;
        logic       sof;
        logic [7:0] chan0;
        logic [7:0] chan1;
    } pix_pair_t;

    // top-left corner of the crop window
    typedef struct packed {
        pos_t row;
        pos_t col;
    } roi_corner_t;

    // single mode sends chan0 only
    typedef enum logic {
        CHAN_DUAL   = 1'b0,
        CHAN_SINGLE = 1'b1
    } chan_mode_e;

    //////////////////////////////////////////////////////////////////////
    // host link

    // one byte on the host link, either direction
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } host_byte_t;

    // frame header, top byte goes out first
    localparam int          MAGIC_BYTES = 8;
    localparam logic [63:0] FRAME_MAGIC = 64'h42_49_56_46_52_41_4D_45;

endpackage

// File: host_cmd_pkg.sv
package host_cmd_pkg;

    //////////////////////////////////////////////////////////////////////
    // command word layout

    // number of host bytes in one command, address first
    localparam int CMD_BYTES = 6;

    // data word, its meaning depends on the register address
    typedef union packed {
        cam_stream_pkg::roi_corner_t corner;
        logic [31:0]                 mode_word;
    } cmd_data_u;

    typedef struct packed {
        logic        valid;
        logic [15:0] addr;
        cmd_data_u   data;
    } host_cmd_t;

    //////////////////////////////////////////////////////////////////////
    // register map

    localparam logic [15:0] REG_ROI_CORNER = 16'h0000;
    localparam logic [15:0] REG_CHAN_MODE  = 16'h0001;

    // mode word bit 0 selects the channel mode
    // 0 = dual channel, 1 = chan0 only
    localparam int MODE_CHAN_BIT = 0;

endpackage

// File: cmd_word_assembler.sv
`timescale 1ns/1ps

module cmd_word_assembler (
    input  logic                       core_clk,
    input  logic                       sys_reset,
    input  cam_stream_pkg::host_byte_t host_rx_i,
    output host_cmd_pkg::host_cmd_t    cmd_o
);
    import host_cmd_pkg::*;

    localparam int CNT_W = $clog2(CMD_BYTES);
    localparam int SH_W  = CMD_BYTES * 8;

    logic [SH_W-1:0]  shift_q;
    logic [CNT_W-1:0] byte_cnt_q;
    logic             cmd_valid_q;

    // payload, first byte ends up on top
    always_ff @(posedge core_clk) begin
        if (host_rx_i.valid) begin
            shift_q <= {shift_q[SH_W-9:0], host_rx_i.data};
        end
    end

    // byte count and command strobe
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            byte_cnt_q  <= '0;
            cmd_valid_q <= 1'b0;
        end else begin
            cmd_valid_q <= 1'b0;
            if (host_rx_i.valid) begin
                if (byte_cnt_q == CNT_W'(CMD_BYTES - 1)) begin
                    byte_cnt_q  <= '0;
                    cmd_valid_q <= 1'b1;
                end else begin
                    byte_cnt_q <= byte_cnt_q + 1'b1;
                end
            end
        end
    end

    // address in the top two bytes, data word below
    always_comb begin
        cmd_o.valid              = cmd_valid_q;
        {cmd_o.addr, cmd_o.data} = shift_q;
    end

endmodule

// File: roi_settings_regs.sv
`timescale 1ns/1ps

module roi_settings_regs #(
    parameter int FRAME_WIDTH = 640,
    parameter int ROI_WIDTH   = 500
) (
    input  logic                        core_clk,
    input  logic                        sys_reset,
    input  host_cmd_pkg::host_cmd_t     cmd_i,
    output cam_stream_pkg::roi_corner_t roi_corner_o,
    output cam_stream_pkg::chan_mode_e  chan_mode_o
);
    import cam_stream_pkg::*;
    import host_cmd_pkg::*;

    // window top aligned and centered horizontally
    localparam pos_t DEFAULT_COL = pos_t'((FRAME_WIDTH - ROI_WIDTH) / 2);

    roi_corner_t corner_q;
    chan_mode_e  mode_q;

    //////////////////////////////////////////////////////////////////////
    // register writes

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            corner_q.row <= '0;
            corner_q.col <= DEFAULT_COL;
            mode_q       <= CHAN_DUAL;
        end else if (cmd_i.valid) begin
            case (cmd_i.addr)
                REG_ROI_CORNER: begin
                    // row in the upper half of the word
                    corner_q <= cmd_i.data.corner;
                end
                REG_CHAN_MODE: begin
                    mode_q <= chan_mode_e'(cmd_i.data.mode_word[MODE_CHAN_BIT]);
                end
                default: begin
                    // addresses outside this bank
                end
            endcase
        end
    end

    // levels, held until the next write
    assign roi_corner_o = corner_q;
    assign chan_mode_o  = mode_q;

endmodule

// File: roi_crop.sv
`timescale 1ns/1ps

module roi_crop #(
    parameter int FRAME_WIDTH  = 640,
    parameter int FRAME_HEIGHT = 480,
    parameter int ROI_WIDTH    = 500,
    parameter int ROI_HEIGHT   = 480
) (
    input  logic                        core_clk,
    input  logic                        sys_reset,
    input  cam_stream_pkg::pix_pair_t   pix_i,
    input  cam_stream_pkg::roi_corner_t roi_corner_i,
    output cam_stream_pkg::pix_pair_t   pix_o
);
    import cam_stream_pkg::*;

    pos_t        col_q;
    pos_t        row_q;
    roi_corner_t corner_q;
    pix_pair_t   pix_q;

    // position and window of the pixel at the input this cycle
    logic        frame_start;
    pos_t        cur_col;
    pos_t        cur_row;
    roi_corner_t cur_corner;
    pos_t        col_off;
    pos_t        row_off;
    logic        in_roi;
    logic        at_origin;

    assign frame_start = pix_i.valid && pix_i.sof;

    always_comb begin
        if (frame_start) begin
            cur_col    = '0;
            cur_row    = '0;
            cur_corner = roi_corner_i;
        end else begin
            cur_col    = col_q;
            cur_row    = row_q;
            cur_corner = corner_q;
        end
        col_off   = cur_col - cur_corner.col;
        row_off   = cur_row - cur_corner.row;
        in_roi    = (cur_col >= cur_corner.col) && (col_off < ROI_WIDTH) &&
                    (cur_row >= cur_corner.row) && (row_off < ROI_HEIGHT);
        at_origin = (col_off == '0) && (row_off == '0);
    end

    //////////////////////////////////////////////////////////////////////
    // row and column tracking

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            col_q    <= '0;
            row_q    <= '0;
            // follow the settings bank until the first frame start
            corner_q <= roi_corner_i;
        end else if (pix_i.valid) begin
            // corner only changes at a frame start
            corner_q <= cur_corner;
            if (cur_col == pos_t'(FRAME_WIDTH - 1)) begin
                col_q <= '0;
                if (cur_row == pos_t'(FRAME_HEIGHT - 1)) begin
                    row_q <= '0;
                end else begin
                    row_q <= cur_row + 1'b1;
                end
            end else begin
                col_q <= cur_col + 1'b1;
                row_q <= cur_row;
            end
        end
    end

    // cropped output, one cycle behind the input
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            pix_q.valid <= 1'b0;
        end else begin
            pix_q.valid <= pix_i.valid && in_roi;
        end
        pix_q.sof   <= in_roi && at_origin;
        pix_q.chan0 <= pix_i.chan0;
        pix_q.chan1 <= pix_i.chan1;
    end

    assign pix_o = pix_q;

endmodule

// File: pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo #(
    parameter int FIFO_DEPTH = 256
) (
    input  logic                      core_clk,
    input  logic                      sys_reset,
    input  cam_stream_pkg::pix_pair_t push_i,
    input  logic                      pop_i,
    output cam_stream_pkg::pix_pair_t head_o,
    output logic                      not_empty_o,
    output logic                      overflow_o
);
    import cam_stream_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    pix_pair_t   mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr_q;
    logic [AW:0] rd_ptr_q;
    logic        full;
    logic        do_push;
    logic        do_pop;
    logic        overflow_q;

    // extra pointer bit tells full from empty
    assign full        = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                         (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);
    assign not_empty_o = (wr_ptr_q != rd_ptr_q);
    assign do_push     = push_i.valid && !full;
    assign do_pop      = pop_i && not_empty_o;

    always_ff @(posedge core_clk) begin
        if (do_push) begin
            mem[wr_ptr_q[AW-1:0]] <= push_i;
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // pixel dropped, flag stays up until reset
            if (push_i.valid && full) begin
                overflow_q <= 1'b1;
            end
        end
    end

    // head entry, valid only while something is stored
    always_comb begin
        head_o       = mem[rd_ptr_q[AW-1:0]];
        head_o.valid = not_empty_o;
    end

    assign overflow_o = overflow_q;

endmodule

// File: frame_serializer.sv
`timescale 1ns/1ps

module frame_serializer (
    input  logic                       core_clk,
    input  logic                       sys_reset,
    input  cam_stream_pkg::pix_pair_t  head_i,
    input  logic                       not_empty_i,
    input  cam_stream_pkg::chan_mode_e chan_mode_i,
    input  logic                       host_ready_i,
    output logic                       pop_o,
    output cam_stream_pkg::host_byte_t host_tx_o
);
    import cam_stream_pkg::*;

    localparam int MAG_W = $clog2(MAGIC_BYTES);

    typedef enum logic [1:0] {
        ST_CHAN0,
        ST_HEADER,
        ST_CHAN1
    } ser_state_e;

    ser_state_e       state_q;
    logic [MAG_W-1:0] mag_cnt_q;
    logic             hdr_done_q;
    chan_mode_e       mode_q;
    host_byte_t       tx_q;

    logic             need_hdr;
    logic             pending;
    logic [7:0]       next_byte;
    logic             send;

    // a frame start entry gets the magic header before its own bytes
    assign need_hdr = not_empty_i && head_i.sof && !hdr_done_q;

    always_comb begin
        pending   = 1'b0;
        next_byte = head_i.chan0;
        case (state_q)
            ST_HEADER: begin
                pending   = 1'b1;
                next_byte = FRAME_MAGIC[(MAGIC_BYTES - 1 - int'(mag_cnt_q)) * 8 +: 8];
            end
            ST_CHAN1: begin
                pending   = 1'b1;
                next_byte = head_i.chan1;
            end
            default: begin
                pending = not_empty_i && !need_hdr;
            end
        endcase
    end

    assign send  = pending && host_ready_i;
    assign pop_o = send && ((state_q == ST_CHAN1) ||
                            ((state_q == ST_CHAN0) && (mode_q == CHAN_SINGLE)));

    //////////////////////////////////////////////////////////////////////
    // state machine

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            state_q    <= ST_CHAN0;
            mag_cnt_q  <= '0;
            hdr_done_q <= 1'b0;
            mode_q     <= CHAN_DUAL;
        end else begin
            case (state_q)
                ST_CHAN0: begin
                    if (need_hdr) begin
                        state_q   <= ST_HEADER;
                        mag_cnt_q <= '0;
                        // mode is fixed for the whole frame
                        mode_q    <= chan_mode_i;
                    end else if (send && (mode_q == CHAN_DUAL)) begin
                        state_q <= ST_CHAN1;
                    end
                end
                ST_HEADER: begin
                    if (send) begin
                        mag_cnt_q <= mag_cnt_q + 1'b1;
                        if (mag_cnt_q == MAG_W'(MAGIC_BYTES - 1)) begin
                            state_q    <= ST_CHAN0;
                            hdr_done_q <= 1'b1;
                        end
                    end
                end
                ST_CHAN1: begin
                    if (send) begin
                        state_q <= ST_CHAN0;
                    end
                end
                default: begin
                    state_q <= ST_CHAN0;
                end
            endcase
            if (pop_o) begin
                hdr_done_q <= 1'b0;
            end
        end
    end

    // registered byte out
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            tx_q.valid <= 1'b0;
        end else begin
            tx_q.valid <= send;
        end
        tx_q.data <= next_byte;
    end

    assign host_tx_o = tx_q;

endmodule

// File: depth_preview_top.sv
`timescale 1ns/1ps

module depth_preview_top #(
    parameter int FRAME_WIDTH  = 640,
    parameter int FRAME_HEIGHT = 480,
    parameter int ROI_WIDTH    = 500,
    parameter int ROI_HEIGHT   = 480,
    parameter int FIFO_DEPTH   = 1024
) (
    input  logic                       core_clk,
    input  logic                       sys_reset,
    input  cam_stream_pkg::pix_pair_t  pix_i,
    input  cam_stream_pkg::host_byte_t host_rx_i,
    input  logic                       host_ready_i,
    output cam_stream_pkg::host_byte_t host_tx_o,
    output logic                       overflow_o
);
    import cam_stream_pkg::*;
    import host_cmd_pkg::*;

    host_cmd_t   host_cmd;
    roi_corner_t roi_corner;
    chan_mode_e  chan_mode;
    pix_pair_t   crop_pix;
    pix_pair_t   fifo_head;
    logic        fifo_not_empty;
    logic        fifo_pop;

    //////////////////////////////////////////////////////////////////////
    // command path

    cmd_word_assembler u_cmd_asm (
        .core_clk  (core_clk),
        .sys_reset (sys_reset),
        .host_rx_i (host_rx_i),
        .cmd_o     (host_cmd)
    );

    roi_settings_regs #(
        .FRAME_WIDTH (FRAME_WIDTH),
        .ROI_WIDTH   (ROI_WIDTH)
    ) u_settings (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .cmd_i        (host_cmd),
        .roi_corner_o (roi_corner),
        .chan_mode_o  (chan_mode)
    );

    //////////////////////////////////////////////////////////////////////
    // crop, buffer and serialize

    roi_crop #(
        .FRAME_WIDTH  (FRAME_WIDTH),
        .FRAME_HEIGHT (FRAME_HEIGHT),
        .ROI_WIDTH    (ROI_WIDTH),
        .ROI_HEIGHT   (ROI_HEIGHT)
    ) u_crop (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .pix_i        (pix_i),
        .roi_corner_i (roi_corner),
        .pix_o        (crop_pix)
    );

    // absorbs the camera stream while the host holds off
    pixel_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .push_i      (crop_pix),
        .pop_i       (fifo_pop),
        .head_o      (fifo_head),
        .not_empty_o (fifo_not_empty),
        .overflow_o  (overflow_o)
    );

    frame_serializer u_serializer (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .head_i       (fifo_head),
        .not_empty_i  (fifo_not_empty),
        .chan_mode_i  (chan_mode),
        .host_ready_i (host_ready_i),
        .pop_o        (fifo_pop),
        .host_tx_o    (host_tx_o)
    );

endmodule

// File: tb_depth_preview.sv
`timescale 1ns/1ps

module tb_depth_preview;
    import cam_stream_pkg::*;
    import host_cmd_pkg::*;

    localparam int FRAME_WIDTH  = 16;
    localparam int FRAME_HEIGHT = 8;
    localparam int ROI_WIDTH    = 10;
    localparam int ROI_HEIGHT   = 6;
    localparam int FIFO_DEPTH   = 256;
    localparam int FRAME_PIX    = FRAME_WIDTH * FRAME_HEIGHT;

    // longest run is a handful of frames at a quarter of full rate
    localparam int TIMEOUT_CYCLES = 6 * FRAME_PIX * 4 + 2000;

    // header text with the first character in the top byte
    localparam logic [63:0] MAGIC_TEXT = "BIVFRAME";

    logic       core_clk;
    logic       sys_reset;
    pix_pair_t  pix_i;
    host_byte_t host_rx_i;
    logic       host_ready_i;
    host_byte_t host_tx_o;
    logic       overflow_o;

    integer      seed = 8;
    int          err_cnt = 0;
    int          check_cnt = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          err_at_start;
    int          cycle_cnt = 0;
    logic        ready_at_edge;
    logic [7:0]  frame_c0 [FRAME_PIX];
    logic [7:0]  frame_c1 [FRAME_PIX];
    host_byte_t  exp_q [$];
    host_byte_t  mon_exp;
    roi_corner_t exp_corner;
    chan_mode_e  exp_mode;
    cmd_data_u   cmd_data;

    depth_preview_top #(
        .FRAME_WIDTH  (FRAME_WIDTH),
        .FRAME_HEIGHT (FRAME_HEIGHT),
        .ROI_WIDTH    (ROI_WIDTH),
        .ROI_HEIGHT   (ROI_HEIGHT),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) dut (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .pix_i        (pix_i),
        .host_rx_i    (host_rx_i),
        .host_ready_i (host_ready_i),
        .host_tx_o    (host_tx_o),
        .overflow_o   (overflow_o)
    );

    initial begin
        core_clk = 1'b0;
        forever #50 core_clk = ~core_clk;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model and compare tasks

    // byte idx of one frame on the host link
    function automatic logic [7:0] ref_byte(input int idx, input roi_corner_t corner,
                                            input chan_mode_e mode);
        int         per_pix;
        int         p;
        int         row;
        int         col;
        logic [7:0] b;
        per_pix = (mode == CHAN_DUAL) ? 2 : 1;
        if (idx < 8) begin
            b = MAGIC_TEXT[(7 - idx) * 8 +: 8];
        end else begin
            p   = (idx - 8) / per_pix;
            row = int'(corner.row) + p / ROI_WIDTH;
            col = int'(corner.col) + p % ROI_WIDTH;
            if ((idx - 8) % per_pix == 0) begin
                b = frame_c0[row * FRAME_WIDTH + col];
            end else begin
                b = frame_c1[row * FRAME_WIDTH + col];
            end
        end
        return b;
    endfunction

    task automatic check_byte(input host_byte_t exp_b, input host_byte_t act_b);
        check_cnt++;
        if (act_b !== exp_b) begin
            err_cnt++;
            $display("Error: host_tx_o expected %03h actual %03h at %0t", exp_b, act_b, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic exp_f, input logic act_f);
        check_cnt++;
        if (act_f !== exp_f) begin
            err_cnt++;
            $display("Error: %s expected %h actual %h at %0t", name, exp_f, act_f, $time);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // output monitor

    always @(posedge core_clk) begin
        ready_at_edge <= host_ready_i;
        cycle_cnt     <= cycle_cnt + 1;
    end

    always @(negedge core_clk) begin
        if (host_tx_o.valid === 1'b1) begin
            if (ready_at_edge !== 1'b1) begin
                err_cnt++;
                $display("A byte left on host_tx_o although host_ready_i was low at %0t", $time);
            end
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("Unexpected byte %02h on host_tx_o with nothing left to send at %0t",
                         host_tx_o.data, $time);
            end else begin
                mon_exp = exp_q.pop_front();
                check_byte(mon_exp, host_tx_o);
            end
        end
    end

    always @(posedge core_clk) begin
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped sending bytes", cycle_cnt);
            $display("Done: errors found");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers

    task automatic apply_reset();
        sys_reset = 1'b1;
        repeat (16) @(negedge core_clk);
        sys_reset = 1'b0;
    endtask

    task automatic send_cmd(input logic [15:0] addr, input cmd_data_u data);
        logic [47:0] word;
        word = {addr, data};
        // address bytes first with the top byte leading
        for (int i = 0; i < CMD_BYTES; i++) begin
            @(negedge core_clk);
            host_rx_i.valid = 1'b1;
            host_rx_i.data  = word[47 - 8 * i -: 8];
        end
        @(negedge core_clk);
        host_rx_i = '0;
        repeat (4) @(negedge core_clk);
    endtask

    task automatic new_frame();
        logic [31:0] rnd;
        for (int i = 0; i < FRAME_PIX; i++) begin
            rnd         = $random(seed);
            frame_c0[i] = rnd[7:0];
            frame_c1[i] = rnd[15:8];
        end
    endtask

    task automatic predict_frame(input roi_corner_t corner, input chan_mode_e mode);
        host_byte_t b;
        int         n;
        n = 8 + ROI_WIDTH * ROI_HEIGHT * ((mode == CHAN_DUAL) ? 2 : 1);
        for (int k = 0; k < n; k++) begin
            b.valid = 1'b1;
            b.data  = ref_byte(k, corner, mode);
            exp_q.push_back(b);
        end
    endtask

    // one full frame on pix_i at one pixel per cycle
    task automatic drive_frame(input logic random_ready);
        logic [31:0] rnd;
        for (int i = 0; i < FRAME_PIX; i++) begin
            @(negedge core_clk);
            pix_i.valid = 1'b1;
            pix_i.sof   = (i == 0);
            pix_i.chan0 = frame_c0[i];
            pix_i.chan1 = frame_c1[i];
            if (random_ready) begin
                rnd          = $random(seed);
                host_ready_i = rnd[0];
            end
        end
        @(negedge core_clk);
        pix_i = '0;
    endtask

    // wait until every predicted byte has been seen
    task automatic drain(input logic random_ready);
        logic [31:0] rnd;
        logic        done;
        done = 1'b0;
        while (!done) begin
            @(posedge core_clk);
            if (exp_q.size() == 0) begin
                done = 1'b1;
            end else begin
                @(negedge core_clk);
                if (random_ready) begin
                    rnd          = $random(seed);
                    host_ready_i = rnd[0];
                end
            end
        end
        @(negedge core_clk);
        host_ready_i = 1'b1;
        // a few idle cycles catch stray bytes
        repeat (8) @(negedge core_clk);
    endtask

    task automatic run_frame(input logic random_ready);
        new_frame();
        predict_frame(exp_corner, exp_mode);
        drive_frame(random_ready);
        drain(random_ready);
    endtask

    task automatic start_test();
        err_at_start = err_cnt;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_cnt == err_at_start) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL with %0d errors", tests_run, name,
                     err_cnt - err_at_start);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        sys_reset    = 1'b1;
        pix_i        = '0;
        host_rx_i    = '0;
        host_ready_i = 1'b1;
        apply_reset();

        // default window at row 0 and column 3 in dual mode
        start_test();
        exp_corner.row = 16'd0;
        exp_corner.col = 16'd3;
        exp_mode       = CHAN_DUAL;
        run_frame(1'b0);
        end_test("reset defaults");

        start_test();
        cmd_data.corner.row = 16'd1;
        cmd_data.corner.col = 16'd2;
        send_cmd(REG_ROI_CORNER, cmd_data);
        exp_corner = cmd_data.corner;
        run_frame(1'b0);
        end_test("corner command");

        start_test();
        cmd_data.mode_word = 32'h0000_0001;
        send_cmd(REG_CHAN_MODE, cmd_data);
        exp_mode = CHAN_SINGLE;
        run_frame(1'b0);
        // would reset both corner and mode if it were decoded
        cmd_data.mode_word = 32'h0000_0000;
        send_cmd(16'h0005, cmd_data);
        run_frame(1'b0);
        end_test("channel mode command");

        start_test();
        cmd_data.mode_word = 32'h0000_0000;
        send_cmd(REG_CHAN_MODE, cmd_data);
        exp_mode = CHAN_DUAL;
        run_frame(1'b1);
        end_test("back-pressure");

        // 5 frames of 60 cropped pixels overrun 256 entries
        start_test();
        check_flag("overflow_o", 1'b0, overflow_o);
        @(negedge core_clk);
        host_ready_i = 1'b0;
        for (int f = 0; f < 5; f++) begin
            new_frame();
            drive_frame(1'b0);
        end
        repeat (4) @(negedge core_clk);
        check_flag("overflow_o", 1'b1, overflow_o);
        repeat (20) @(negedge core_clk);
        check_flag("overflow_o", 1'b1, overflow_o);
        apply_reset();
        @(negedge core_clk);
        check_flag("overflow_o", 1'b0, overflow_o);
        end_test("overflow");

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: all.f
cam_stream_pkg.sv
host_cmd_pkg.sv
cmd_word_assembler.sv
roi_settings_regs.sv
roi_crop.sv
pixel_fifo.sv
frame_serializer.sv
depth_preview_top.sv
tb_depth_preview.sv
